/* list.f */
logic/dmg_clk_pkg.sv
logic/phase_gen.sv
logic/reset_seq.sv
logic/div_counter.sv
logic/apu_frame_gen.sv
logic/clocks_reset.sv
sim/clocks_reset_tb.sv

/* logic/apu_frame_gen.sv */
`timescale 1ns/1ps

module apu_frame_gen
	import dmg_clk_pkg::*;
(
	input  logic   clkin_a,
	input  logic   rst,
	input  logic   apu_reset,
	input  logic   frame_tick,
	output frame_t frame
);

	logic [STEP_WIDTH-1:0] step_q;
	logic [STEP_WIDTH-1:0] step_next;
	logic                  f512_q;
	logic                  f256_q;
	logic                  f128_q;

	assign step_next = step_q + 1'b1;   // Wraps at 8

	always_ff @(posedge clkin_a) begin
		if (rst || apu_reset) begin
			step_q <= '0;
			f512_q <= 1'b0;
			f256_q <= 1'b0;
			f128_q <= 1'b0;
		end else if (frame_tick) begin
			step_q <= step_next;
			f512_q <= 1'b1;
			f256_q <= (step_next[0] == 1'b0);      // Every second tick
			f128_q <= (step_next[1:0] == 2'b00);   // Every fourth tick
		end else begin
			f512_q <= 1'b0;
			f256_q <= 1'b0;
			f128_q <= 1'b0;
		end
	end

	assign frame.f512 = f512_q;
	assign frame.f256 = f256_q;
	assign frame.f128 = f128_q;
	assign frame.step = step_q;

endmodule

/* logic/clocks_reset.sv */
`timescale 1ns/1ps

module clocks_reset
	import dmg_clk_pkg::*;
(
	input  logic                clkin_a,
	input  logic                rst,
	input  logic                reset_pin,
	input  logic                lcd_on,
	input  logic                apu_reset,
	input  cpu_bus_t            bus,
	output clk_phase_t          clk_phase,
	output logic                to_cpu,
	output logic                nreset2,
	output logic                reset_video,
	output logic [RD_WIDTH-1:0] rdata,
	output logic                rd_valid,
	output div_taps_t           taps,
	output frame_t              frame
);

	clk_phase_t phase_w;
	logic       sys_rst;
	logic       frame_tick;

	phase_gen phase_gen_i (
		.clkin_a   (clkin_a),
		.rst       (rst),
		.clk_phase (phase_w)
	);

	reset_seq reset_seq_i (
		.clkin_a     (clkin_a),
		.rst         (rst),
		.reset_pin   (reset_pin),
		.lcd_on      (lcd_on),
		.clk_phase   (phase_w),
		.sys_rst     (sys_rst),
		.nreset2     (nreset2),
		.reset_video (reset_video)
	);

	div_counter div_counter_i (
		.clkin_a    (clkin_a),
		.rst        (rst),
		.sys_rst    (sys_rst),
		.clk_phase  (phase_w),
		.bus        (bus),
		.rdata      (rdata),
		.rd_valid   (rd_valid),
		.taps       (taps),
		.frame_tick (frame_tick)
	);

	apu_frame_gen apu_frame_gen_i (
		.clkin_a    (clkin_a),
		.rst        (rst),
		.apu_reset  (apu_reset),
		.frame_tick (frame_tick),
		.frame      (frame)
	);

	assign clk_phase = phase_w;
	assign to_cpu    = phase_w.cpu_en;   // CPU clock enable

endmodule

/* logic/div_counter.sv */
`timescale 1ns/1ps

module div_counter
	import dmg_clk_pkg::*;
(
	input  logic                clkin_a,
	input  logic                rst,
	input  logic                sys_rst,
	input  clk_phase_t          clk_phase,
	input  cpu_bus_t            bus,
	output logic [RD_WIDTH-1:0] rdata,
	output logic                rd_valid,
	output div_taps_t           taps,
	output logic                frame_tick
);

	logic [DIV_WIDTH-1:0] div_q;
	logic [RD_WIDTH-1:0]  rdata_q;
	logic                 rd_valid_q;
	logic                 tap_q;
	logic                 div_sel;
	logic                 div_wr;
	logic                 div_rd;

	// Only FF04 inside the window is decoded
	assign div_sel = bus.io_sel && (bus.addr == 2'(ADDR_DIV));
	assign div_wr  = div_sel && bus.wr;   // Data is ignored
	assign div_rd  = div_sel && bus.rd;

	always_ff @(posedge clkin_a) begin
		if (rst || sys_rst || div_wr)
			div_q <= '0;
		else if (clk_phase.cpu_en)
			div_q <= div_q + 1'b1;
	end

	always_ff @(posedge clkin_a) begin
		if (rst) begin
			rd_valid_q <= 1'b0;
			tap_q      <= 1'b0;
		end else begin
			rd_valid_q <= div_rd;
			tap_q      <= div_q[FRAME_TAP];
		end
	end

	// High byte as it stood in the strobe cycle
	always_ff @(posedge clkin_a) begin
		if (div_rd)
			rdata_q <= div_q[DIV_READ_LSB +: RD_WIDTH];
	end

	assign rdata    = rdata_q;
	assign rd_valid = rd_valid_q;

	// A clear from a write also counts as a falling edge
	assign frame_tick = tap_q && !div_q[FRAME_TAP];

	assign taps.t262k = div_q[1];
	assign taps.t65k  = div_q[3];
	assign taps.t16k  = div_q[5];

endmodule

/* logic/dmg_clk_pkg.sv */
package dmg_clk_pkg;

	localparam int DIV_WIDTH         = 14;
	localparam int DIV_READ_LSB      = 6;   // FF04 shows bits 13..6
	localparam int FRAME_TAP         = 10;  // 512 Hz source bit
	localparam int RESET_HOLD_CYCLES = 8;
	localparam int HOLD_CNT_WIDTH    = 3;
	localparam int ADDR_DIV          = 0;   // Offset of FF04 in FF04-FF07
	localparam int RD_WIDTH          = 8;
	localparam int STEP_WIDTH        = 3;

	typedef enum logic [1:0] {
		PH_A,
		PH_B,
		PH_C,
		PH_D
	} phase_t;

	typedef enum logic [1:0] {
		RS_HOLD,
		RS_COUNT,
		RS_RUN
	} rst_state_t;

	typedef struct packed {
		phase_t phase;
		logic   cpu_en;   // 1 MHz CPU enable
		logic   apu_en;   // 2 MHz audio enable
		logic   phi;
	} clk_phase_t;

	typedef struct packed {
		logic                io_sel;   // FF04-FF07 window
		logic [1:0]          addr;
		logic                rd;
		logic                wr;
		logic [RD_WIDTH-1:0] wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic t262k;
		logic t65k;
		logic t16k;
	} div_taps_t;

	typedef struct packed {
		logic                  f512;
		logic                  f256;
		logic                  f128;
		logic [STEP_WIDTH-1:0] step;
	} frame_t;

endpackage

/* logic/phase_gen.sv */
`timescale 1ns/1ps

module phase_gen
	import dmg_clk_pkg::*;
(
	input  logic       clkin_a,
	input  logic       rst,
	output clk_phase_t clk_phase
);

	clk_phase_t ph_q;
	phase_t     phase_next;

	// Four-phase ring held as an enum register
	always_comb begin
		case (ph_q.phase)
			PH_A:    phase_next = PH_B;
			PH_B:    phase_next = PH_C;
			PH_C:    phase_next = PH_D;
			PH_D:    phase_next = PH_A;
			default: phase_next = PH_A;
		endcase
	end

	// Enables are decoded from the next phase so they line up with it
	always_ff @(posedge clkin_a) begin
		if (rst) begin
			ph_q.phase  <= PH_A;
			ph_q.cpu_en <= 1'b0;
			ph_q.apu_en <= 1'b0;
			ph_q.phi    <= 1'b0;
		end else begin
			ph_q.phase  <= phase_next;
			ph_q.cpu_en <= (phase_next == PH_D);                           // Once per 4
			ph_q.apu_en <= (phase_next == PH_B) || (phase_next == PH_D);   // Twice per 4
			ph_q.phi    <= (phase_next == PH_C) || (phase_next == PH_D);   // Second half
		end
	end

	assign clk_phase = ph_q;

endmodule

/* logic/reset_seq.sv */
`timescale 1ns/1ps

module reset_seq
	import dmg_clk_pkg::*;
(
	input  logic       clkin_a,
	input  logic       rst,
	input  logic       reset_pin,
	input  logic       lcd_on,
	input  clk_phase_t clk_phase,
	output logic       sys_rst,
	output logic       nreset2,
	output logic       reset_video
);

	logic [1:0]                pin_sync;
	rst_state_t                state;
	rst_state_t                state_next;
	logic [HOLD_CNT_WIDTH-1:0] hold_cnt;
	logic                      hold_done;

	assign hold_done = clk_phase.cpu_en &&
		(hold_cnt == HOLD_CNT_WIDTH'(RESET_HOLD_CYCLES - 1));

	always_comb begin
		state_next = state;
		if (pin_sync[1]) begin
			state_next = RS_HOLD;   // Pin high wins in every state
		end else begin
			case (state)
				RS_HOLD:  state_next = RS_COUNT;
				RS_COUNT: state_next = hold_done ? RS_RUN : RS_COUNT;
				RS_RUN:   state_next = RS_RUN;
				default:  state_next = RS_HOLD;
			endcase
		end
	end

	always_ff @(posedge clkin_a) begin
		if (rst) begin
			pin_sync <= 2'b11;   // Treat pin as asserted
			state    <= RS_HOLD;
			hold_cnt <= '0;
		end else begin
			pin_sync <= {pin_sync[0], reset_pin};
			state    <= state_next;
			if (state_next != RS_COUNT)
				hold_cnt <= '0;
			else if (clk_phase.cpu_en)
				hold_cnt <= hold_cnt + 1'b1;
		end
	end

	assign sys_rst     = (state != RS_RUN);
	assign nreset2     = ~sys_rst;
	assign reset_video = ~((state == RS_RUN) && lcd_on);   // LCD enable gate

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module clocks_reset_tb -f list.f \
	&& ./obj_dir/Vclocks_reset_tb 2>&1 | tee sim.log \
	|| { echo "Build or run of the simulation failed"; exit 1; }

grep -qx "Test passed" sim.log && echo "Simulation PASS" \
	|| { echo "Simulation FAIL, see sim.log"; exit 1; }

/* sim/clocks_reset_tb.sv */
`timescale 1ns/1ps

module clocks_reset_tb
	import dmg_clk_pkg::*;
();

	localparam int          CLK_PERIOD      = 40;
	localparam int          DRIVE_DELAY     = 2;
	localparam logic [31:0] LFSR_SEED       = 32'd86255;
	localparam logic [31:0] LFSR_TAPS       = 32'hA3000000;
	localparam int          READ_COUNT      = 40;
	localparam int          WRITE_COUNT     = 20;
	localparam int          FRAME_TICKS_MIN = 9;
	localparam int          FRAME_PERIOD    = 4 * (2 ** (FRAME_TAP + 1));   // Cycles per tick
	localparam int          PLANNED_CYCLES  = 400 + READ_COUNT * 64 + WRITE_COUNT * 100 +
		FRAME_TICKS_MIN * FRAME_PERIOD + 400;
	localparam int          WATCHDOG_CYCLES = PLANNED_CYCLES + PLANNED_CYCLES / 10;

	logic                clk = 1'b0;
	logic                rst;
	logic                reset_pin;
	logic                lcd_on;
	logic                apu_reset;
	cpu_bus_t            bus;
	clk_phase_t          clk_phase;
	logic                to_cpu;
	logic                nreset2;
	logic                reset_video;
	logic [RD_WIDTH-1:0] rdata;
	logic                rd_valid;
	div_taps_t           taps;
	frame_t              frame;

	// Reference model state
	logic [1:0]           m_phase;
	logic [1:0]           m_pin_sync;
	rst_state_t           m_state;
	int                   m_hold;
	logic [DIV_WIDTH-1:0] m_div;
	logic                 m_tap_prev;
	logic                 m_rd_valid;
	logic [7:0]           m_rdata;
	logic [2:0]           m_step;
	logic [2:0]           m_step_next;
	logic                 m_f512;
	logic                 m_f256;
	logic                 m_f128;
	logic                 m_cpu_en;
	logic                 m_apu_en;
	logic                 m_phi;
	logic                 m_running;
	logic                 m_div_rd;
	logic                 m_div_wr;
	logic                 m_tick;
	int                   tick_count = 0;
	int                   read_pulses = 0;
	logic [31:0]          lfsr_state = LFSR_SEED;

	clocks_reset clocks_reset_i (
		.clkin_a     (clk),
		.rst         (rst),
		.reset_pin   (reset_pin),
		.lcd_on      (lcd_on),
		.apu_reset   (apu_reset),
		.bus         (bus),
		.clk_phase   (clk_phase),
		.to_cpu      (to_cpu),
		.nreset2     (nreset2),
		.reset_video (reset_video),
		.rdata       (rdata),
		.rd_valid    (rd_valid),
		.taps        (taps),
		.frame       (frame)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return val;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
		$display("Test failed");
		$fatal(1, "Stopping at first mismatch");
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic bus_access(input logic [1:0] addr, input logic rd, input logic wr,
		input logic [7:0] data);
		bus.io_sel = 1'b1;
		bus.addr   = addr;
		bus.rd     = rd;
		bus.wr     = wr;
		bus.wdata  = data;
		next_cycle();
		bus = '0;
	endtask

	task automatic wait_release();
		while (!nreset2)
			next_cycle();
	endtask

	assign m_cpu_en    = (m_phase == 2'd3);
	assign m_apu_en    = (m_phase == 2'd1) || (m_phase == 2'd3);   // PH_B and PH_D
	assign m_phi       = (m_phase == 2'd2) || (m_phase == 2'd3);   // PH_C and PH_D
	assign m_running   = (m_state == RS_RUN);
	assign m_div_rd    = bus.io_sel && bus.rd && (bus.addr == 2'(ADDR_DIV));
	assign m_div_wr    = bus.io_sel && bus.wr && (bus.addr == 2'(ADDR_DIV));
	assign m_tick      = m_tap_prev && !m_div[FRAME_TAP];   // Falling edge of bit 10
	assign m_step_next = m_step + 3'd1;

	always @(posedge clk) begin
		if (rst) begin
			m_phase    <= 2'd0;
			m_pin_sync <= 2'b11;
			m_state    <= RS_HOLD;
			m_hold     <= 0;
			m_tap_prev <= 1'b0;
			m_rd_valid <= 1'b0;
		end else begin
			m_phase    <= m_phase + 2'd1;
			m_pin_sync <= {m_pin_sync[0], reset_pin};
			m_tap_prev <= m_div[FRAME_TAP];
			m_rd_valid <= m_div_rd;
			if (m_pin_sync[1]) begin
				m_state <= RS_HOLD;
				m_hold  <= 0;
			end else if (m_state == RS_HOLD) begin
				m_state <= RS_COUNT;
				m_hold  <= m_cpu_en ? 1 : 0;   // Enable on the entry edge counts
			end else if (m_state == RS_COUNT && m_cpu_en) begin
				if (m_hold + 1 == RESET_HOLD_CYCLES) begin
					m_state <= RS_RUN;
					m_hold  <= 0;
				end else begin
					m_hold <= m_hold + 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (rst || !m_running || m_div_wr)
			m_div <= '0;
		else if (m_cpu_en)
			m_div <= m_div + 1'b1;
		if (m_div_rd)
			m_rdata <= m_div[DIV_WIDTH-1:DIV_READ_LSB];
	end

	always @(posedge clk) begin
		if (rst || apu_reset) begin
			m_step <= 3'd0;
			m_f512 <= 1'b0;
			m_f256 <= 1'b0;
			m_f128 <= 1'b0;
		end else if (m_tick) begin
			m_step <= m_step_next;
			m_f512 <= 1'b1;
			m_f256 <= (m_step_next % 3'd2 == 3'd0);
			m_f128 <= (m_step_next % 3'd4 == 3'd0);
		end else begin
			m_f512 <= 1'b0;
			m_f256 <= 1'b0;
			m_f128 <= 1'b0;
		end
		if (!rst && m_tick)
			tick_count <= tick_count + 1;
		if (!rst && m_rd_valid)
			read_pulses <= read_pulses + 1;
	end

	// Checked at the falling edge where everything is settled
	a_phase: assert property (@(negedge clk) disable iff (rst) 2'(clk_phase.phase) == m_phase)
		else report_mismatch("clk_phase.phase", 32'(clk_phase.phase), 32'(m_phase));
	a_cpu_en: assert property (@(negedge clk) disable iff (rst) clk_phase.cpu_en == m_cpu_en)
		else report_mismatch("clk_phase.cpu_en", 32'(clk_phase.cpu_en), 32'(m_cpu_en));
	a_apu_en: assert property (@(negedge clk) disable iff (rst) clk_phase.apu_en == m_apu_en)
		else report_mismatch("clk_phase.apu_en", 32'(clk_phase.apu_en), 32'(m_apu_en));
	a_phi: assert property (@(negedge clk) disable iff (rst) clk_phase.phi == m_phi)
		else report_mismatch("clk_phase.phi", 32'(clk_phase.phi), 32'(m_phi));
	a_to_cpu: assert property (@(negedge clk) disable iff (rst) to_cpu == m_cpu_en)
		else report_mismatch("to_cpu", 32'(to_cpu), 32'(m_cpu_en));
	a_nreset2: assert property (@(negedge clk) disable iff (rst) nreset2 == m_running)
		else report_mismatch("nreset2", 32'(nreset2), 32'(m_running));
	a_video: assert property (@(negedge clk) disable iff (rst)
		reset_video == !(m_running && lcd_on))
		else report_mismatch("reset_video", 32'(reset_video), 32'(!(m_running && lcd_on)));
	a_rd_valid: assert property (@(negedge clk) disable iff (rst) rd_valid == m_rd_valid)
		else report_mismatch("rd_valid", 32'(rd_valid), 32'(m_rd_valid));
	a_rdata: assert property (@(negedge clk) disable iff (rst) !m_rd_valid || rdata == m_rdata)
		else report_mismatch("rdata", 32'(rdata), 32'(m_rdata));
	a_t262k: assert property (@(negedge clk) disable iff (rst) taps.t262k == m_div[1])
		else report_mismatch("taps.t262k", 32'(taps.t262k), 32'(m_div[1]));
	a_t65k: assert property (@(negedge clk) disable iff (rst) taps.t65k == m_div[3])
		else report_mismatch("taps.t65k", 32'(taps.t65k), 32'(m_div[3]));
	a_t16k: assert property (@(negedge clk) disable iff (rst) taps.t16k == m_div[5])
		else report_mismatch("taps.t16k", 32'(taps.t16k), 32'(m_div[5]));
	a_f512: assert property (@(negedge clk) disable iff (rst) frame.f512 == m_f512)
		else report_mismatch("frame.f512", 32'(frame.f512), 32'(m_f512));
	a_f256: assert property (@(negedge clk) disable iff (rst) frame.f256 == m_f256)
		else report_mismatch("frame.f256", 32'(frame.f256), 32'(m_f256));
	a_f128: assert property (@(negedge clk) disable iff (rst) frame.f128 == m_f128)
		else report_mismatch("frame.f128", 32'(frame.f128), 32'(m_f128));
	a_step: assert property (@(negedge clk) disable iff (rst) frame.step == m_step)
		else report_mismatch("frame.step", 32'(frame.step), 32'(m_step));

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Simulation timed out before the tests finished");
		$display("Test failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		int   start_ticks;
		logic apu_pulsed;
		apu_pulsed = 1'b0;
		rst        = 1'b1;
		reset_pin  = 1'b1;
		lcd_on     = 1'b0;
		apu_reset  = 1'b0;
		bus        = '0;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		wait_cycles(20);   // Pin held, then released
		reset_pin = 1'b0;
		wait_release();
		wait_cycles(40);
		lcd_on = 1'b1;
		wait_cycles(10);
		reset_pin = 1'b1;   // Later pin pulse
		wait_cycles(6);
		reset_pin = 1'b0;
		wait_release();

		repeat (READ_COUNT) begin
			wait_cycles(take_bits(6));
			lcd_on = (take_bits(1) != 0);
			bus_access(2'(ADDR_DIV), 1'b1, 1'b0, 8'h00);
		end

		repeat (WRITE_COUNT) begin
			wait_cycles(take_bits(6));
			bus_access(2'(ADDR_DIV), 1'b0, 1'b1, 8'(take_bits(8)));
			wait_cycles(take_bits(5));
			bus_access(2'(ADDR_DIV), 1'b1, 1'b0, 8'h00);
			if (take_bits(1) != 0)
				bus_access(2'(take_bits(2) % 3 + 1), 1'b1, 1'b0, 8'h00);
			else
				bus_access(2'(take_bits(2) % 3 + 1), 1'b0, 1'b1, 8'(take_bits(8)));
		end

		// Long run for the frame sequencer
		start_ticks = tick_count;
		while (tick_count - start_ticks < FRAME_TICKS_MIN) begin
			wait_cycles(64 + take_bits(8));
			bus_access(2'(ADDR_DIV), 1'b1, 1'b0, 8'h00);
			if (!apu_pulsed && tick_count - start_ticks >= 4) begin
				apu_reset = 1'b1;
				next_cycle();
				apu_reset  = 1'b0;
				apu_pulsed = 1'b1;
			end
		end
		wait_cycles(4);

		if (tick_count < FRAME_TICKS_MIN || read_pulses < READ_COUNT || !apu_pulsed) begin
			$display("Run ended without enough frame ticks, DIV reads or audio resets");
			$display("Test failed");
			$fatal(1, "Stimulus did not reach all checks");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule
